//--- hdl/lmem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lmem_pkg
// shared widths, address map and router
// states for the local memory subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package lmem_pkg;

    // basic widths
    localparam int WORD_W = 32;
    localparam int WORD_ADDR_W = 30;
    localparam int BE_W = WORD_W / 8;
    localparam int UART_W = 8;

    // data word and byte lanes
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BE_W-1:0] be_t;

    // word address, byte offset bits dropped
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

    // one captured uart character
    typedef logic [UART_W-1:0] uart_byte_t;

    // router dispatch states
    typedef enum logic [1:0] {
        route_idle,
        route_bram,
        route_periph_wait
    } router_state_e;

    // peripheral region, byte address 0x1000_0000 and up
    // well above any allowed ram depth
    localparam word_addr_t PERIPH_BASE = 30'h0400_0000;

    // uart data register, byte offset 0x1000 into the region
    localparam word_addr_t UART_WORD_ADDR = 30'h0400_0400;

    // every peripheral read returns this
    localparam word_t PERIPH_READ_VALUE = 32'hffff_ff21;

endpackage

`default_nettype wire

//--- hdl/lmem_req_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lmem_req_if
// single request plus read response
// between the router and a target
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface lmem_req_if;

    // request side
    logic                  valid;
    lmem_pkg::word_addr_t  addr;
    lmem_pkg::be_t         be;
    lmem_pkg::word_t       wdata;
    logic                  rnw;

    // response side, rd_valid only for reads
    logic                  rd_valid;
    lmem_pkg::word_t       rd_data;
    logic                  busy;

    modport requester (output valid, addr, be, wdata, rnw,
                       input  rd_valid, rd_data, busy);

    modport responder (input  valid, addr, be, wdata, rnw,
                       output rd_valid, rd_data, busy);

endinterface

`default_nettype wire

//--- hdl/byte_en_bram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte_en_bram
// dual-port ram, read-only instruction port A,
// byte-enable data port B, one-cycle reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module byte_en_bram #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                 clk,
    input  logic                 a_en,
    input  lmem_pkg::word_addr_t a_addr,
    output lmem_pkg::word_t      a_rdata,
    output logic                 a_rvalid,
    lmem_req_if.responder        port_b
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    lmem_pkg::word_t mem [MEM_WORDS];

    // ram contents start cleared
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // port A, instruction fetch
    always_ff @(posedge clk) begin
        a_rvalid <= a_en;
        if (a_en) begin
            a_rdata <= mem[a_addr[IDX_W-1:0]];
        end
    end

    // port B, read first then byte-lane writes
    always @(posedge clk) begin
        port_b.rd_valid <= port_b.valid && port_b.rnw;
        if (port_b.valid) begin
            port_b.rd_data <= mem[port_b.addr[IDX_W-1:0]];
            for (int lane = 0; lane < 4; lane++) begin
                if (!port_b.rnw && port_b.be[lane]) begin
                    mem[port_b.addr[IDX_W-1:0]][8*lane +: 8] <= port_b.wdata[8*lane +: 8];
                end
            end
        end
    end

    // single-cycle target, always ready
    assign port_b.busy = 1'b0;

endmodule

`default_nettype wire

//--- hdl/data_port_router.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data_port_router
// credit-counted request queue with in-order
// dispatch to the ram or the peripheral stub
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module data_port_router #(
    parameter int REQ_CREDITS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    input  lmem_pkg::word_addr_t req_addr,
    input  lmem_pkg::be_t        req_be,
    input  lmem_pkg::word_t      req_wdata,
    input  logic                 req_rnw,
    output logic                 credit,
    output logic                 rsp_valid,
    output lmem_pkg::word_t      rsp_data,
    lmem_req_if.requester        bram,
    lmem_req_if.requester        periph
);

    localparam int PTR_W = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
    localparam int CNT_W = $clog2(REQ_CREDITS + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(REQ_CREDITS - 1);

    // queue payload
    lmem_pkg::word_addr_t q_addr  [REQ_CREDITS];
    lmem_pkg::be_t        q_be    [REQ_CREDITS];
    lmem_pkg::word_t      q_wdata [REQ_CREDITS];
    logic                 q_rnw   [REQ_CREDITS];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    lmem_pkg::router_state_e state;
    logic head_periph;
    logic hold;
    logic deq;

    // head decode against the peripheral base
    assign head_periph = (q_addr[rd_ptr] >= lmem_pkg::PERIPH_BASE);
    // keep order behind an outstanding peripheral access
    assign hold = (state == lmem_pkg::route_periph_wait) && periph.busy;

    assign bram.valid = (q_count != '0) && !head_periph && !hold && !bram.busy;
    assign periph.valid = (q_count != '0) && head_periph && !periph.busy;
    assign deq = bram.valid || periph.valid;

    // both targets see the head entry
    assign bram.addr = q_addr[rd_ptr];
    assign bram.be = q_be[rd_ptr];
    assign bram.wdata = q_wdata[rd_ptr];
    assign bram.rnw = q_rnw[rd_ptr];
    assign periph.addr = q_addr[rd_ptr];
    assign periph.be = q_be[rd_ptr];
    assign periph.wdata = q_wdata[rd_ptr];
    assign periph.rnw = q_rnw[rd_ptr];

    // credit goes back on each dequeue
    assign credit = deq;

    // responses never overlap, stub takes priority
    assign rsp_valid = bram.rd_valid || periph.rd_valid;
    assign rsp_data = periph.rd_valid ? periph.rd_data : bram.rd_data;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_addr[wr_ptr] <= req_addr;
            q_be[wr_ptr] <= req_be;
            q_wdata[wr_ptr] <= req_wdata;
            q_rnw[wr_ptr] <= req_rnw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
            state <= lmem_pkg::route_idle;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy
            if (req_valid && !deq) begin
                q_count <= q_count + 1'b1;
            end else if (!req_valid && deq) begin
                q_count <= q_count - 1'b1;
            end
            // track where the last dispatch went
            if (deq) begin
                state <= head_periph ? lmem_pkg::route_periph_wait : lmem_pkg::route_bram;
            end else if (!hold) begin
                state <= lmem_pkg::route_idle;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/periph_bus_stub.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// periph_bus_stub
// peripheral slave with fixed countdown,
// constant read data and uart byte capture
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module periph_bus_stub #(
    parameter int PERIPH_LATENCY = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    lmem_req_if.responder        bus,
    output logic                 uart_valid,
    output lmem_pkg::uart_byte_t uart_byte
);

    localparam int CNT_W = $clog2(PERIPH_LATENCY + 1);
    localparam logic [CNT_W-1:0] LAT_LAST = CNT_W'(PERIPH_LATENCY - 1);

    logic [CNT_W-1:0]     count;
    lmem_pkg::word_addr_t addr_q;
    logic                 rnw_q;
    logic                 accept;

    assign accept = bus.valid && !bus.busy;

    // reads always return the same word
    assign bus.rd_data = lmem_pkg::PERIPH_READ_VALUE;

    // latched request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= bus.addr;
            rnw_q <= bus.rnw;
            // low byte, only used for uart writes
            uart_byte <= bus.wdata[7:0];
        end
    end

    // countdown, busy while it runs
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.busy <= 1'b0;
            bus.rd_valid <= 1'b0;
            uart_valid <= 1'b0;
            count <= '0;
        end else begin
            // single-cycle pulses by default
            bus.rd_valid <= 1'b0;
            uart_valid <= 1'b0;
            if (accept) begin
                bus.busy <= 1'b1;
                count <= LAT_LAST;
            end else if (bus.busy) begin
                if (count == '0) begin
                    bus.busy <= 1'b0;
                    bus.rd_valid <= rnw_q;
                    // writes elsewhere in the region vanish
                    uart_valid <= !rnw_q && (addr_q == lmem_pkg::UART_WORD_ADDR);
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/lmem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lmem_top
// local memory subsystem, ram plus
// data router and peripheral stub
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lmem_top #(
    parameter int MEM_WORDS = 1024,
    parameter int REQ_CREDITS = 4,
    parameter int PERIPH_LATENCY = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    // instruction port, fixed latency
    input  logic                 inst_valid,
    input  lmem_pkg::word_addr_t inst_addr,
    output logic                 inst_rd_valid,
    output lmem_pkg::word_t      inst_rd_data,
    // data port, credit based
    input  logic                 data_valid,
    input  lmem_pkg::word_addr_t data_addr,
    input  lmem_pkg::be_t        data_be,
    input  lmem_pkg::word_t      data_wdata,
    input  logic                 data_rnw,
    output logic                 data_credit,
    output logic                 data_rd_valid,
    output lmem_pkg::word_t      data_rd_data,
    // uart capture
    output logic                 uart_valid,
    output lmem_pkg::uart_byte_t uart_byte
);

    lmem_req_if bram_bus ();
    lmem_req_if periph_bus ();

    byte_en_bram #(.MEM_WORDS(MEM_WORDS)) u_bram (
        .clk      (clk),
        .a_en     (inst_valid),
        .a_addr   (inst_addr),
        .a_rdata  (inst_rd_data),
        .a_rvalid (inst_rd_valid),
        .port_b   (bram_bus.responder)
    );

    data_port_router #(.REQ_CREDITS(REQ_CREDITS)) u_router (
        .clk       (clk),
        .rst       (rst),
        .req_valid (data_valid),
        .req_addr  (data_addr),
        .req_be    (data_be),
        .req_wdata (data_wdata),
        .req_rnw   (data_rnw),
        .credit    (data_credit),
        .rsp_valid (data_rd_valid),
        .rsp_data  (data_rd_data),
        .bram      (bram_bus.requester),
        .periph    (periph_bus.requester)
    );

    periph_bus_stub #(.PERIPH_LATENCY(PERIPH_LATENCY)) u_stub (
        .clk        (clk),
        .rst        (rst),
        .bus        (periph_bus.responder),
        .uart_valid (uart_valid),
        .uart_byte  (uart_byte)
    );

endmodule

`default_nettype wire

//--- sim/lmem_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lmem_checker
// reset, instruction latency and credit
// accounting assertions, bound into lmem_top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lmem_checker #(
    parameter int REQ_CREDITS = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic inst_valid,
    input  logic inst_rd_valid,
    input  logic data_valid,
    input  logic data_credit,
    input  logic data_rd_valid,
    input  logic uart_valid
);

    // requests sitting in the router queue
    int queued;

    always_ff @(posedge clk) begin
        if (rst) begin
            queued <= 0;
        end else begin
            queued <= queued + int'(data_valid) - int'(data_credit);
        end
    end

    // all valid outputs quiet right after reset
    assert property (@(posedge clk) $fell(rst) |->
                     !(inst_rd_valid || data_rd_valid || data_credit || uart_valid))
        else $error("valid output high in the first cycle after reset");

    // fixed one-cycle fetch
    assert property (@(posedge clk) disable iff (rst) inst_rd_valid == $past(inst_valid))
        else $error("inst_rd_valid does not follow inst_valid by one cycle");

    assert property (@(posedge clk) disable iff (rst) queued <= REQ_CREDITS)
        else $error("router queue holds more requests than credits");

    // a credit only comes back for a queued request
    assert property (@(posedge clk) disable iff (rst) data_credit |-> queued > 0)
        else $error("credit returned with the router queue empty");

endmodule

bind lmem_top lmem_checker #(
    .REQ_CREDITS(REQ_CREDITS)
) u_checker (
    .clk           (clk),
    .rst           (rst),
    .inst_valid    (inst_valid),
    .inst_rd_valid (inst_rd_valid),
    .data_valid    (data_valid),
    .data_credit   (data_credit),
    .data_rd_valid (data_rd_valid),
    .uart_valid    (uart_valid)
);

`default_nettype wire

//--- sim/lmem_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lmem_tb
// random traffic on both ports of lmem_top,
// checked against a shadow memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module lmem_tb;

    localparam int MEM_WORDS = 1024;
    localparam int REQ_CREDITS = 4;
    localparam int PERIPH_LATENCY = 5;
    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int NUM_OPS = 400;
    // every op waiting out the stub, plus reset and drain
    localparam int CYCLE_LIMIT = NUM_OPS * (PERIPH_LATENCY + 3) + 100;
    // a full queue of stub accesses, worst case
    localparam int DRAIN_LIMIT = REQ_CREDITS * (PERIPH_LATENCY + 3) + 4;
    localparam logic [31:0] SEED = 32'hcfc1_4950;

    typedef struct packed {
        logic                 rnw;
        lmem_pkg::be_t        be;
        lmem_pkg::word_addr_t addr;
        lmem_pkg::word_t      wdata;
    } data_req_t;

    logic                 clk;
    logic                 rst;
    logic                 inst_valid;
    lmem_pkg::word_addr_t inst_addr;
    logic                 inst_rd_valid;
    lmem_pkg::word_t      inst_rd_data;
    logic                 data_valid;
    lmem_pkg::word_addr_t data_addr;
    lmem_pkg::be_t        data_be;
    lmem_pkg::word_t      data_wdata;
    logic                 data_rnw;
    logic                 data_credit;
    logic                 data_rd_valid;
    lmem_pkg::word_t      data_rd_data;
    logic                 uart_valid;
    lmem_pkg::uart_byte_t uart_byte;

    // model of ram contents as dispatched
    lmem_pkg::word_t      shadow [MEM_WORDS];
    // sent but not yet taken off the router queue
    data_req_t            pend_q [$];
    lmem_pkg::word_t      rd_expect_q [$];
    lmem_pkg::uart_byte_t uart_expect_q [$];
    logic                 inst_pend;
    lmem_pkg::word_t      inst_expect;
    int                   credits;
    int                   ops_sent;
    int                   drain_cycles;
    int                   cycle_count = 0;
    logic [31:0]          rng;

    lmem_top #(
        .MEM_WORDS      (MEM_WORDS),
        .REQ_CREDITS    (REQ_CREDITS),
        .PERIPH_LATENCY (PERIPH_LATENCY)
    ) u_dut (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("TB FAILED");
            $fatal(1, "timeout, traffic did not drain within %0d cycles", CYCLE_LIMIT);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %s: expected %h, actual %h", name, exp, act);
        $display("TB FAILED");
        $fatal(1, "value mismatch in %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("TB FAILED");
        $fatal(1, "%s", what);
    endtask

    // outputs from the last rising edge
    task automatic check_responses();
        lmem_pkg::word_t      exp_word;
        lmem_pkg::uart_byte_t exp_byte;
        assert (inst_rd_valid == inst_pend)
            else abort_run("inst_rd_valid did not follow inst_valid by one cycle");
        if (inst_pend) begin
            assert (inst_rd_data == inst_expect)
                else report_mismatch("inst read", inst_expect, inst_rd_data);
        end
        if (data_rd_valid) begin
            assert (rd_expect_q.size() != 0)
                else abort_run("data read response with no read outstanding");
            exp_word = rd_expect_q.pop_front();
            assert (data_rd_data == exp_word)
                else report_mismatch("data read", exp_word, data_rd_data);
        end
        if (uart_valid) begin
            assert (uart_expect_q.size() != 0)
                else abort_run("uart_valid without a uart write outstanding");
            exp_byte = uart_expect_q.pop_front();
            assert (uart_byte == exp_byte)
                else report_mismatch("uart byte", {24'h0, exp_byte}, {24'h0, uart_byte});
        end
    endtask

    task automatic drive_stimulus(input bit allow);
        data_req_t  req;
        logic [3:0] kind;
        logic       send;
        // fetch about half the cycles, same window as data
        rng = xorshift(rng);
        inst_valid = allow && rng[0];
        inst_addr = lmem_pkg::word_addr_t'(rng[7:1]);
        inst_pend = inst_valid;
        // ram is read before this edge's data write lands
        inst_expect = shadow[rng[7:1]];
        rng = xorshift(rng);
        kind = rng[3:0];
        req.addr = lmem_pkg::word_addr_t'(rng[10:4]);
        req.rnw = rng[11];
        req.be = rng[15:12];
        // idle one cycle in eight, and never without a credit
        send = allow && (credits > 0) && (rng[18:16] != 3'd0);
        rng = xorshift(rng);
        req.wdata = rng;
        case (kind)
            4'd8, 4'd9: begin
                req.addr = lmem_pkg::PERIPH_BASE + req.addr;
                req.rnw = 1'b1;
            end
            4'd10, 4'd11: begin
                req.addr = lmem_pkg::UART_WORD_ADDR;
                req.rnw = 1'b0;
            end
            4'd12: begin
                // offset below the uart register, write gets dropped
                req.addr = lmem_pkg::PERIPH_BASE + req.addr;
                req.rnw = 1'b0;
            end
            default: begin
            end
        endcase
        data_valid = send;
        data_addr = req.addr;
        data_be = req.be;
        data_wdata = req.wdata;
        data_rnw = req.rnw;
        if (send) begin
            pend_q.push_back(req);
            credits--;
            ops_sent++;
        end
    endtask

    // credit high now means the head dispatches at the next edge
    task automatic track_dispatch();
        data_req_t        head;
        logic [IDX_W-1:0] idx;
        if (data_credit) begin
            assert (pend_q.size() != 0)
                else abort_run("credit returned with no request queued");
            head = pend_q.pop_front();
            idx = head.addr[IDX_W-1:0];
            credits++;
            if (head.addr >= lmem_pkg::PERIPH_BASE) begin
                if (head.rnw) begin
                    rd_expect_q.push_back(lmem_pkg::PERIPH_READ_VALUE);
                end else if (head.addr == lmem_pkg::UART_WORD_ADDR) begin
                    uart_expect_q.push_back(head.wdata[7:0]);
                end
            end else if (head.rnw) begin
                rd_expect_q.push_back(shadow[idx]);
            end else begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (head.be[lane]) begin
                        shadow[idx][8*lane +: 8] = head.wdata[8*lane +: 8];
                    end
                end
            end
        end
    endtask

    task automatic run_cycle(input bit allow);
        @(negedge clk);
        check_responses();
        drive_stimulus(allow);
        track_dispatch();
    endtask

    initial begin
        rst = 1'b1;
        inst_valid = 1'b0;
        inst_addr = '0;
        data_valid = 1'b0;
        data_addr = '0;
        data_be = '0;
        data_wdata = '0;
        data_rnw = 1'b0;
        inst_pend = 1'b0;
        inst_expect = '0;
        credits = REQ_CREDITS;
        ops_sent = 0;
        drain_cycles = 0;
        rng = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // no stimulus yet
        repeat (4) begin
            @(negedge clk);
            assert (!(inst_rd_valid || data_rd_valid || data_credit || uart_valid))
                else abort_run("valid output high after reset before any stimulus");
        end
        while (ops_sent < NUM_OPS) begin
            run_cycle(1'b1);
        end
        // drain queue and late responses, worst case bounded
        while ((pend_q.size() != 0 || rd_expect_q.size() != 0 ||
                uart_expect_q.size() != 0 || inst_pend) &&
               drain_cycles < DRAIN_LIMIT) begin
            run_cycle(1'b0);
            drain_cycles++;
        end
        assert (credits == REQ_CREDITS)
            else report_mismatch("credit count", REQ_CREDITS, credits);
        assert (rd_expect_q.size() == 0 && uart_expect_q.size() == 0)
            else abort_run("expected responses never arrived");
        // stray responses would show up here
        repeat (PERIPH_LATENCY + 2) run_cycle(1'b0);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/lmem_pkg.sv
hdl/lmem_req_if.sv
hdl/byte_en_bram.sv
hdl/data_port_router.sv
hdl/periph_bus_stub.sv
hdl/lmem_top.sv
sim/lmem_checker.sv
sim/lmem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the local memory testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module lmem_tb -f vlog.f -o lmem_sim

# tee keeps the log even when the simulation stops early
./obj_dir/lmem_sim 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "simulation ended without passing"
    exit 1
fi
echo "simulation passed"
